/* source/cramPkg.sv */
package cramPkg;

  localparam int cramWidth = 84;

  // Raw microword, bit 0 on the left as in the KL10 prints
  typedef logic [0:cramWidth-1] tCramWord;

  // Jump address, bits 1..11
  typedef logic [0:10] tCRAM_J;

  // ALU function and its input selects
  typedef logic [0:5] tCRAM_AD;
  typedef logic [0:2] tCRAM_ADA;
  typedef logic [0:1] tCRAM_ADB;

  // Register load selects
  typedef logic [0:2] tCRAM_AR;
  typedef logic [0:2] tCRAM_ARX;
  typedef logic [0:2] tCRAM_FMADR;
  typedef logic [0:2] tCRAM_SCAD;
  typedef logic [0:1] tCRAM_SH;

  // Memory control
  typedef logic [0:1] tCRAM_VMA;
  typedef logic [0:1] tCRAM_TIME;
  typedef logic [0:3] tCRAM_MEM;

  // Sequencer control, bits 60..71
  typedef logic [0:5] tCRAM_SKIP;
  typedef logic [0:4] tCRAM_DISP;

  // Bits 75..83, sub-decodes not modelled
  typedef logic [0:8] tCRAM_MAGIC;

  localparam tCRAM_DISP dispNone = 5'd0;
  localparam tCRAM_DISP dispReturn = 5'd1;
  localparam tCRAM_DISP dispDram = 5'd2;

  localparam tCRAM_SKIP skipNone = 6'd0;

  // Selected by the low three SKIP bits
  localparam int skipCondCount = 8;

endpackage

/* source/seqPkg.sv */
package seqPkg;

  localparam int cradrWidth = 11;
  localparam int cramDepth = 2048;

  typedef logic [0:cradrWidth-1] tCradr;

  // Return stack geometry
  localparam int stackDepth = 4;
  localparam int stackIdxWidth = 2;

  typedef logic [stackIdxWidth-1:0] tStackIdx;
  // Entry count, 0 means empty
  typedef logic [stackIdxWidth:0] tStackPtr;

  localparam tStackPtr stackFull = tStackPtr'(stackDepth);

  // Dispatch input ORs into the low bits of the address
  localparam int dispWidth = 4;
  localparam int adrLow = cradrWidth - 1;
  localparam int dispLow = cradrWidth - dispWidth;

endpackage

/* source/cramMem.sv */
`timescale 1ns/1ps

module cramMem (
  input logic eboxClk,
  input logic rstN,
  input seqPkg::tCradr readAddr,
  output cramPkg::tCramWord readData,
  input logic writeEn,
  input seqPkg::tCradr writeAddr,
  input cramPkg::tCramWord writeData
);
  import cramPkg::*;
  import seqPkg::*;

  tCramWord mem [cramDepth];

  // Loader port
  always_ff @(posedge eboxClk) begin
    if (writeEn) begin
      mem[writeAddr] <= writeData;
    end
  end

  // Output register, zero after reset so every field reads as a no-op
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      readData <= '0;
    end else begin
      readData <= mem[readAddr];
    end
  end

endmodule

/* source/crm.sv */
`timescale 1ns/1ps

// CRAM field decode
//
// Bit numbers follow the KL10 convention, bit 0 is the MSB
module crm (
  input cramPkg::tCramWord CRAMdata,
  output cramPkg::tCRAM_J CRAM_J,
  output cramPkg::tCRAM_AD CRAM_AD,
  output cramPkg::tCRAM_ADA CRAM_ADA,
  output cramPkg::tCRAM_ADB CRAM_ADB,
  output cramPkg::tCRAM_AR CRAM_AR,
  output cramPkg::tCRAM_ARX CRAM_ARX,
  output logic CRAM_BR,
  output logic CRAM_BRX,
  output logic CRAM_MQ,
  output cramPkg::tCRAM_FMADR CRAM_FMADR,
  output cramPkg::tCRAM_SCAD CRAM_SCAD,
  output cramPkg::tCRAM_SH CRAM_SH,
  output cramPkg::tCRAM_VMA CRAM_VMA,
  output cramPkg::tCRAM_TIME CRAM_TIME,
  output cramPkg::tCRAM_MEM CRAM_MEM,
  output cramPkg::tCRAM_SKIP CRAM_SKIP,
  output logic CRAM_CALL,
  output cramPkg::tCRAM_DISP CRAM_DISP,
  output logic CRAM_MARK,
  output cramPkg::tCRAM_MAGIC CRAM_MAGIC
);
  import cramPkg::*;

  always_comb begin
    CRAM_J = tCRAM_J'(CRAMdata[1:11]);

    // Datapath steering
    CRAM_AD = tCRAM_AD'(CRAMdata[12:17]);
    CRAM_ADA = tCRAM_ADA'(CRAMdata[18:20]);
    CRAM_ADB = tCRAM_ADB'(CRAMdata[22:23]);
    CRAM_AR = tCRAM_AR'(CRAMdata[24:26]);
    CRAM_ARX = tCRAM_ARX'(CRAMdata[27:29]);
    CRAM_BR = CRAMdata[30];
    CRAM_BRX = CRAMdata[31];
    CRAM_MQ = CRAMdata[32];
    CRAM_FMADR = tCRAM_FMADR'(CRAMdata[33:35]);
    CRAM_SCAD = tCRAM_SCAD'(CRAMdata[36:38]);
    CRAM_SH = tCRAM_SH'(CRAMdata[49:50]);

    // Memory cycle control
    CRAM_VMA = tCRAM_VMA'(CRAMdata[52:53]);
    CRAM_TIME = tCRAM_TIME'(CRAMdata[54:55]);
    CRAM_MEM = tCRAM_MEM'(CRAMdata[56:59]);

    // Sequencer
    CRAM_SKIP = tCRAM_SKIP'(CRAMdata[60:65]);
    CRAM_CALL = CRAMdata[66];
    CRAM_DISP = tCRAM_DISP'(CRAMdata[67:71]);

    CRAM_MARK = CRAMdata[74];
    CRAM_MAGIC = tCRAM_MAGIC'(CRAMdata[75:83]);
  end

endmodule

/* source/microSeq.sv */
`timescale 1ns/1ps

module microSeq (
  input logic eboxClk,
  input logic rstN,
  input logic run,
  input cramPkg::tCRAM_J CRAM_J,
  input cramPkg::tCRAM_SKIP CRAM_SKIP,
  input logic CRAM_CALL,
  input cramPkg::tCRAM_DISP CRAM_DISP,
  input logic [cramPkg::skipCondCount-1:0] skipCond,
  input logic [seqPkg::dispWidth-1:0] dispIn,
  input logic loadEn,
  output seqPkg::tCradr CRADR,
  output seqPkg::tCradr nextAdr
);
  import cramPkg::*;
  import seqPkg::*;

  tCradr stack [stackDepth];
  tStackPtr sp;
  tStackPtr popCount;
  tStackPtr spNext;
  tCradr topAdr;
  tCradr baseAdr;
  tCradr stepAdr;
  tCradr retAdr;
  logic isReturn;
  logic doPop;

  assign isReturn = CRAM_DISP == dispReturn;
  assign doPop = isReturn && (sp != '0);

  // Return from an empty stack lands on 0
  assign topAdr = doPop ? stack[tStackIdx'(sp - tStackPtr'(1))] : '0;
  assign retAdr = CRADR + tCradr'(1);

  // Pop first, then push on top of what is left
  always_comb begin
    popCount = doPop ? sp - tStackPtr'(1) : sp;
    if (!CRAM_CALL) begin
      spNext = popCount;
    end else if (popCount == stackFull) begin
      spNext = stackFull;
    end else begin
      spNext = popCount + tStackPtr'(1);
    end
  end

  always_comb begin
    baseAdr = isReturn ? topAdr : CRAM_J;
    stepAdr = baseAdr;

    if (CRAM_SKIP != skipNone) begin
      stepAdr[adrLow] = stepAdr[adrLow] | skipCond[CRAM_SKIP[3:5]];
    end

    if (CRAM_DISP == dispDram) begin
      stepAdr[dispLow +: dispWidth] = stepAdr[dispLow +: dispWidth] | dispIn;
    end

    // Stalled machine keeps rereading the current word
    nextAdr = run ? stepAdr : CRADR;
  end

  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      CRADR <= '0;
      sp <= '0;
    end else if (run) begin
      CRADR <= nextAdr;
      sp <= spNext;
    end
  end

  always_ff @(posedge eboxClk) begin
    if (run && CRAM_CALL) begin
      if (popCount == stackFull) begin
        // Full, oldest return address falls off the bottom
        for (int i = 0; i < stackDepth - 1; i++) begin
          stack[i] <= stack[i + 1];
        end
        stack[stackDepth - 1] <= retAdr;
      end else begin
        stack[tStackIdx'(popCount)] <= retAdr;
      end
    end
  end

  spInRange: assert property (
    @(posedge eboxClk) disable iff (!rstN)
    sp <= stackFull
  );

  // Loader only writes while the machine is stopped
  noLoadWhileRun: assert property (
    @(posedge eboxClk) disable iff (!rstN)
    !(loadEn && run)
  );

  holdOnStall: assert property (
    @(posedge eboxClk) disable iff (!rstN)
    !run |=> $stable(CRADR)
  );

endmodule

/* source/controlStore.sv */
`timescale 1ns/1ps

module controlStore (
  input logic eboxClk,
  input logic rstN,
  input logic loadEn,
  input seqPkg::tCradr loadAddr,
  input cramPkg::tCramWord loadData,
  input logic run,
  input logic [cramPkg::skipCondCount-1:0] skipCond,
  input logic [seqPkg::dispWidth-1:0] dispIn,
  output seqPkg::tCradr CRADR,
  output cramPkg::tCRAM_J CRAM_J,
  output cramPkg::tCRAM_AD CRAM_AD,
  output cramPkg::tCRAM_ADA CRAM_ADA,
  output cramPkg::tCRAM_ADB CRAM_ADB,
  output cramPkg::tCRAM_AR CRAM_AR,
  output cramPkg::tCRAM_ARX CRAM_ARX,
  output logic CRAM_BR,
  output logic CRAM_BRX,
  output logic CRAM_MQ,
  output cramPkg::tCRAM_FMADR CRAM_FMADR,
  output cramPkg::tCRAM_SCAD CRAM_SCAD,
  output cramPkg::tCRAM_SH CRAM_SH,
  output cramPkg::tCRAM_VMA CRAM_VMA,
  output cramPkg::tCRAM_TIME CRAM_TIME,
  output cramPkg::tCRAM_MEM CRAM_MEM,
  output cramPkg::tCRAM_SKIP CRAM_SKIP,
  output logic CRAM_CALL,
  output cramPkg::tCRAM_DISP CRAM_DISP,
  output logic CRAM_MARK,
  output cramPkg::tCRAM_MAGIC CRAM_MAGIC
);
  import cramPkg::*;
  import seqPkg::*;

  tCramWord cramWord;
  tCradr nextAdr;

  cramMem cram0 (
    .eboxClk(eboxClk),
    .rstN(rstN),
    .readAddr(nextAdr),
    .readData(cramWord),
    .writeEn(loadEn),
    .writeAddr(loadAddr),
    .writeData(loadData)
  );

  crm crm0 (
    .CRAMdata(cramWord),
    .CRAM_J(CRAM_J),
    .CRAM_AD(CRAM_AD),
    .CRAM_ADA(CRAM_ADA),
    .CRAM_ADB(CRAM_ADB),
    .CRAM_AR(CRAM_AR),
    .CRAM_ARX(CRAM_ARX),
    .CRAM_BR(CRAM_BR),
    .CRAM_BRX(CRAM_BRX),
    .CRAM_MQ(CRAM_MQ),
    .CRAM_FMADR(CRAM_FMADR),
    .CRAM_SCAD(CRAM_SCAD),
    .CRAM_SH(CRAM_SH),
    .CRAM_VMA(CRAM_VMA),
    .CRAM_TIME(CRAM_TIME),
    .CRAM_MEM(CRAM_MEM),
    .CRAM_SKIP(CRAM_SKIP),
    .CRAM_CALL(CRAM_CALL),
    .CRAM_DISP(CRAM_DISP),
    .CRAM_MARK(CRAM_MARK),
    .CRAM_MAGIC(CRAM_MAGIC)
  );

  // Address for the next read comes from the fields of the current word
  microSeq seq0 (
    .eboxClk(eboxClk),
    .rstN(rstN),
    .run(run),
    .CRAM_J(CRAM_J),
    .CRAM_SKIP(CRAM_SKIP),
    .CRAM_CALL(CRAM_CALL),
    .CRAM_DISP(CRAM_DISP),
    .skipCond(skipCond),
    .dispIn(dispIn),
    .loadEn(loadEn),
    .CRADR(CRADR),
    .nextAdr(nextAdr)
  );

endmodule

/* test/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
  output logic eboxClk,
  output logic rstN
);
  localparam int halfPeriod = 5;
  localparam int resetCycles = 10;

  initial begin
    eboxClk = 1'b0;
    forever begin
      #(halfPeriod) eboxClk = ~eboxClk;
    end
  end

  // Release lines up with the testbench drive point
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) begin
      @(posedge eboxClk);
    end
    #1 rstN = 1'b1;
  end

endmodule

/* test/controlStoreTb.sv */
`timescale 1ns/1ps

module controlStoreTb;
  import cramPkg::*;
  import seqPkg::*;

  localparam int clkPeriod = 10;
  localparam int runSteps = 3000;
  localparam int reloadLen = 8;
  localparam int reloadSteps = 16;
  localparam int slackCycles = 100;
  localparam int timeoutNs = (cramDepth + runSteps + slackCycles) * clkPeriod * 2;

  logic eboxClk;
  logic rstN;
  logic loadEn;
  tCradr loadAddr;
  tCramWord loadData;
  logic run;
  logic [skipCondCount-1:0] skipCond;
  logic [dispWidth-1:0] dispIn;
  tCradr CRADR;
  tCRAM_J CRAM_J;
  tCRAM_AD CRAM_AD;
  tCRAM_ADA CRAM_ADA;
  tCRAM_ADB CRAM_ADB;
  tCRAM_AR CRAM_AR;
  tCRAM_ARX CRAM_ARX;
  logic CRAM_BR;
  logic CRAM_BRX;
  logic CRAM_MQ;
  tCRAM_FMADR CRAM_FMADR;
  tCRAM_SCAD CRAM_SCAD;
  tCRAM_SH CRAM_SH;
  tCRAM_VMA CRAM_VMA;
  tCRAM_TIME CRAM_TIME;
  tCRAM_MEM CRAM_MEM;
  tCRAM_SKIP CRAM_SKIP;
  logic CRAM_CALL;
  tCRAM_DISP CRAM_DISP;
  logic CRAM_MARK;
  tCRAM_MAGIC CRAM_MAGIC;

  // Reference model state
  integer seed;
  tCramWord modelMem [cramDepth];
  tCramWord modelWord;
  logic [10:0] modelCradr;
  logic [10:0] modelStack [$];
  int overflowCount;
  int emptyReturnCount;

  clockGen clk0 (
    .eboxClk(eboxClk),
    .rstN(rstN)
  );

  controlStore dut0 (.*);

  // Bits first..last of a microword, bit 0 being the MSB
  function automatic logic [15:0] fieldOf(input tCramWord word, input int first, input int last);
    logic [83:0] flat;
    logic [83:0] mask;
    flat = word;
    mask = (84'd1 << (last - first + 1)) - 84'd1;
    return 16'((flat >> (83 - last)) & mask);
  endfunction

  task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // Random microword, skewed toward calls, returns and DRAM dispatch
  task automatic makeWord(output tCramWord w);
    int pick;
    w = 84'({$random(seed), $random(seed), $random(seed)});
    pick = int'($unsigned($random(seed)) % 8);
    case (pick)
      0, 1, 2: begin
        w[66] = 1'b0;
        w[67:71] = dispReturn;
      end
      3: w[67:71] = dispDram;
      4, 5: begin
        w[66] = 1'b1;
        w[67:71] = dispNone;
      end
      default: ;
    endcase
  endtask

  // Advance the model across one rising edge using the inputs now driven
  task automatic predictEdge();
    logic [10:0] nextAdr;
    logic [5:0] skip;
    logic [4:0] disp;
    nextAdr = modelCradr;
    if (run) begin
      skip = 6'(fieldOf(modelWord, 60, 65));
      disp = 5'(fieldOf(modelWord, 67, 71));
      if (disp == dispReturn) begin
        if (modelStack.size() > 0) begin
          nextAdr = modelStack.pop_back();
        end else begin
          nextAdr = 11'd0;
          emptyReturnCount++;
        end
      end else begin
        nextAdr = 11'(fieldOf(modelWord, 1, 11));
      end
      if (skip != 6'd0) begin
        nextAdr[0] = nextAdr[0] | skipCond[skip[2:0]];
      end
      if (disp == dispDram) begin
        nextAdr[3:0] = nextAdr[3:0] | dispIn;
      end
      if (modelWord[66]) begin
        if (modelStack.size() == stackDepth) begin
          void'(modelStack.pop_front());
          overflowCount++;
        end
        modelStack.push_back(modelCradr + 11'd1);
      end
    end
    // Read sees the old contents when the same edge writes
    modelWord = modelMem[nextAdr];
    if (loadEn) begin
      modelMem[loadAddr] = loadData;
    end
    modelCradr = nextAdr;
  endtask

  task automatic checkOutputs(input logic withFields);
    compare("CRADR", 16'(CRADR), 16'(modelCradr));
    if (withFields) begin
      compare("CRAM_J", 16'(CRAM_J), fieldOf(modelWord, 1, 11));
      compare("CRAM_AD", 16'(CRAM_AD), fieldOf(modelWord, 12, 17));
      compare("CRAM_ADA", 16'(CRAM_ADA), fieldOf(modelWord, 18, 20));
      compare("CRAM_ADB", 16'(CRAM_ADB), fieldOf(modelWord, 22, 23));
      compare("CRAM_AR", 16'(CRAM_AR), fieldOf(modelWord, 24, 26));
      compare("CRAM_ARX", 16'(CRAM_ARX), fieldOf(modelWord, 27, 29));
      compare("CRAM_BR", 16'(CRAM_BR), fieldOf(modelWord, 30, 30));
      compare("CRAM_BRX", 16'(CRAM_BRX), fieldOf(modelWord, 31, 31));
      compare("CRAM_MQ", 16'(CRAM_MQ), fieldOf(modelWord, 32, 32));
      compare("CRAM_FMADR", 16'(CRAM_FMADR), fieldOf(modelWord, 33, 35));
      compare("CRAM_SCAD", 16'(CRAM_SCAD), fieldOf(modelWord, 36, 38));
      compare("CRAM_SH", 16'(CRAM_SH), fieldOf(modelWord, 49, 50));
      compare("CRAM_VMA", 16'(CRAM_VMA), fieldOf(modelWord, 52, 53));
      compare("CRAM_TIME", 16'(CRAM_TIME), fieldOf(modelWord, 54, 55));
      compare("CRAM_MEM", 16'(CRAM_MEM), fieldOf(modelWord, 56, 59));
      compare("CRAM_SKIP", 16'(CRAM_SKIP), fieldOf(modelWord, 60, 65));
      compare("CRAM_CALL", 16'(CRAM_CALL), fieldOf(modelWord, 66, 66));
      compare("CRAM_DISP", 16'(CRAM_DISP), fieldOf(modelWord, 67, 71));
      compare("CRAM_MARK", 16'(CRAM_MARK), fieldOf(modelWord, 74, 74));
      compare("CRAM_MAGIC", 16'(CRAM_MAGIC), fieldOf(modelWord, 75, 83));
    end
  endtask

  task automatic clockStep(input logic withFields);
    predictEdge();
    @(posedge eboxClk);
    #1;
    checkOutputs(withFields);
  endtask

  task automatic loadWord(input logic [10:0] addr, input tCramWord w);
    loadEn = 1'b1;
    loadAddr = addr;
    loadData = w;
    clockStep(1'b1);
  endtask

  task automatic loadAll();
    tCramWord w;
    for (int i = 0; i < cramDepth; i++) begin
      makeWord(w);
      loadEn = 1'b1;
      loadAddr = tCradr'(i);
      loadData = w;
      // First read still returns the unloaded word at address 0
      clockStep(i != 0);
    end
    loadEn = 1'b0;
    clockStep(1'b1);
  endtask

  task automatic runRandom();
    tCradr held;
    for (int n = 0; n < runSteps; n++) begin
      run = ($unsigned($random(seed)) % 10) != 0;
      skipCond = 8'($random(seed));
      dispIn = 4'($random(seed));
      held = CRADR;
      clockStep(1'b1);
      if (!run) begin
        compare("CRADR", 16'(CRADR), 16'(held));
      end
    end
    run = 1'b0;
  endtask

  // Rewrite the current word to enter a looping chain of fresh words
  task automatic reloadAndRun();
    tCramWord w;
    logic [10:0] start;
    logic [10:0] chainBase;
    logic [10:0] addr;
    logic [10:0] expectAdr;
    start = CRADR;
    chainBase = (start ^ 11'h400) & 11'h7f0;
    for (int i = 0; i <= reloadLen; i++) begin
      addr = (i == reloadLen) ? start : chainBase + 11'(i);
      makeWord(w);
      w[1:11] = (i == reloadLen - 1 || i == reloadLen) ? chainBase : addr + 11'd1;
      w[60:65] = skipNone;
      w[66] = 1'b0;
      w[67:71] = dispNone;
      loadWord(addr, w);
    end
    loadEn = 1'b0;
    clockStep(1'b1);
    compare("CRAM_J", 16'(CRAM_J), 16'(chainBase));
    run = 1'b1;
    for (int n = 0; n < reloadSteps; n++) begin
      skipCond = 8'($random(seed));
      dispIn = 4'($random(seed));
      expectAdr = chainBase + 11'(n % reloadLen);
      clockStep(1'b1);
      compare("CRADR", 16'(CRADR), 16'(expectAdr));
    end
    run = 1'b0;
  endtask

  initial begin
    #(timeoutNs);
    $display("Watchdog expired before the tests finished");
    $display("Simulation failed");
    $fatal(1);
  end

  initial begin
    seed = 32'h589b;
    loadEn = 1'b0;
    loadAddr = '0;
    loadData = '0;
    run = 1'b0;
    skipCond = '0;
    dispIn = '0;
    modelCradr = 11'd0;
    modelWord = '0;
    overflowCount = 0;
    emptyReturnCount = 0;

    wait (rstN === 1'b1);
    checkOutputs(1'b1);

    loadAll();
    runRandom();
    reloadAndRun();

    if (overflowCount == 0 || emptyReturnCount == 0) begin
      $display("The random run never overflowed the stack or returned from an empty one");
      $display("Simulation failed");
      $fatal(1);
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

/* project.f */
source/cramPkg.sv
source/seqPkg.sv
source/cramMem.sv
source/crm.sv
source/microSeq.sv
source/controlStore.sv
test/clockGen.sv
test/controlStoreTb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f project.f --top-module controlStoreTb

status=0
./obj_dir/VcontrolStoreTb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit $status
